/* hw/exu_pkg.sv */
// execute slice package: widths, opcodes, operation encodings and control bundle
package exu_pkg;

  localparam int XLEN = 64;
  localparam int ILEN = 32;

  // major opcodes
  localparam logic [6:0] OPC_LUI      = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
  localparam logic [6:0] OPC_JAL      = 7'b1101111;
  localparam logic [6:0] OPC_JALR     = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
  localparam logic [6:0] OPC_LOAD     = 7'b0000011;
  localparam logic [6:0] OPC_STORE    = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP_IMM32 = 7'b0011011;
  localparam logic [6:0] OPC_OP       = 7'b0110011;
  localparam logic [6:0] OPC_OP_32    = 7'b0111011;
  localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_ALT    = 7'b0100000;
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  localparam logic [ILEN-1:0] INST_EBREAK = 32'h0010_0073;

  typedef enum logic [4:0] {
    ALU_ADD  = 5'b00000,
    ALU_SLL  = 5'b00001,
    ALU_SLT  = 5'b00010,
    ALU_COPY = 5'b00011,
    ALU_XOR  = 5'b00100,
    ALU_SRL  = 5'b00101,
    ALU_OR   = 5'b00110,
    ALU_AND  = 5'b00111,
    ALU_SUB  = 5'b01000,
    ALU_SLTU = 5'b01010,
    ALU_SRA  = 5'b01101,
    ALU_REMU = 5'b11001,
    ALU_DIVU = 5'b11010,
    ALU_DIV  = 5'b11011,
    ALU_MUL  = 5'b11100,
    ALU_REM  = 5'b11101
  } alu_op_e;

  typedef enum logic [1:0] {
    BSEL_RS2  = 2'b00,
    BSEL_IMM  = 2'b01,
    BSEL_FOUR = 2'b10
  } bsel_e;

  // upper bit marks the unsigned compares
  typedef enum logic [3:0] {
    BR_NONE = 4'b0000,
    BR_JAL  = 4'b0001,
    BR_JALR = 4'b0010,
    BR_EQ   = 4'b0100,
    BR_NE   = 4'b0101,
    BR_LT   = 4'b0110,
    BR_GE   = 4'b0111,
    BR_LTU  = 4'b1110,
    BR_GEU  = 4'b1111
  } branch_e;

  typedef enum logic [2:0] {
    MEM_LB  = 3'b000,
    MEM_LBU = 3'b001,
    MEM_LH  = 3'b010,
    MEM_LHU = 3'b011,
    MEM_LW  = 3'b100,
    MEM_LWU = 3'b101,
    MEM_LD  = 3'b110
  } mem_op_e;

  typedef struct packed {
    alu_op_e    alu_op;
    logic       a_sel_pc;
    bsel_e      b_sel;
    logic       word_cut;
    branch_e    branch;
    mem_op_e    mem_op;
    logic       mem_to_reg;
    logic       reg_wen;
    logic [4:0] rd;
    logic       halt;
    logic       illegal;
  } exu_ctrl_t;

endpackage

/* hw/exu_stage_if.sv */
// stage-to-stage links of the execute slice, valid strobe plus payload
`timescale 1ns/1ps

// decode to execute
interface dec_exe_if import exu_pkg::*; ();
  logic            valid;
  exu_ctrl_t       ctrl;
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] rs1;
  logic [XLEN-1:0] rs2;
  logic [XLEN-1:0] imm;
  logic [XLEN-1:0] rdata;

  modport src (
    output valid, ctrl, pc, rs1, rs2, imm, rdata
  );

  modport dst (
    input valid, ctrl, pc, rs1, rs2, imm, rdata
  );
endinterface

// execute to writeback
interface exe_wb_if import exu_pkg::*; ();
  logic            valid;
  exu_ctrl_t       ctrl;
  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] nextpc;
  logic [XLEN-1:0] rdata;

  modport src (
    output valid, ctrl, alu_result, nextpc, rdata
  );

  modport dst (
    input valid, ctrl, alu_result, nextpc, rdata
  );
endinterface

/* hw/idu_decode.sv */
// decode stage: instruction word to control bundle and immediate, one register stage
`timescale 1ns/1ps

module idu_decode import exu_pkg::*; (
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic            i_valid,
  input  logic [ILEN-1:0] i_inst,
  input  logic [XLEN-1:0] i_pc,
  input  logic [XLEN-1:0] i_rs1,
  input  logic [XLEN-1:0] i_rs2,
  input  logic [XLEN-1:0] i_rdata,
  dec_exe_if.src          o_exe
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic            is_word;
  logic            dec_bad;
  exu_ctrl_t       dec_ctrl;
  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [XLEN-1:0] dec_imm;

  assign opcode  = i_inst[6:0];
  assign funct3  = i_inst[14:12];
  assign funct7  = i_inst[31:25];
  assign is_word = (opcode == OPC_OP_32) || (opcode == OPC_OP_IMM32);

  assign imm_i = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_u = {{(XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  always_comb begin
    case (opcode)
      OPC_LUI, OPC_AUIPC:  dec_imm = imm_u;
      OPC_JAL:             dec_imm = imm_j;
      OPC_BRANCH:          dec_imm = imm_b;
      OPC_STORE:           dec_imm = imm_s;
      default:             dec_imm = imm_i;
    endcase
  end

  always_comb begin
    dec_ctrl            = '0;
    dec_ctrl.alu_op     = ALU_ADD;
    dec_ctrl.b_sel      = BSEL_RS2;
    dec_ctrl.branch     = BR_NONE;
    dec_ctrl.mem_op     = MEM_LD;
    dec_ctrl.word_cut   = is_word;
    dec_bad             = 1'b0;

    case (opcode)
      OPC_LUI: begin
        dec_ctrl.alu_op  = ALU_COPY;
        dec_ctrl.reg_wen = 1'b1;
      end
      OPC_AUIPC: begin
        dec_ctrl.a_sel_pc = 1'b1;
        dec_ctrl.b_sel    = BSEL_IMM;
        dec_ctrl.reg_wen  = 1'b1;
      end
      // link value pc+4 comes from the alu
      OPC_JAL, OPC_JALR: begin
        dec_ctrl.a_sel_pc = 1'b1;
        dec_ctrl.b_sel    = BSEL_FOUR;
        dec_ctrl.reg_wen  = 1'b1;
        dec_ctrl.branch   = (opcode == OPC_JAL) ? BR_JAL : BR_JALR;
        dec_bad           = (opcode == OPC_JALR) && (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        dec_ctrl.alu_op = ALU_SUB;
        case (funct3)
          3'b000:  dec_ctrl.branch = BR_EQ;
          3'b001:  dec_ctrl.branch = BR_NE;
          3'b100:  dec_ctrl.branch = BR_LT;
          3'b101:  dec_ctrl.branch = BR_GE;
          3'b110:  dec_ctrl.branch = BR_LTU;
          3'b111:  dec_ctrl.branch = BR_GEU;
          default: dec_bad = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        dec_ctrl.b_sel      = BSEL_IMM;
        dec_ctrl.mem_to_reg = 1'b1;
        dec_ctrl.reg_wen    = 1'b1;
        case (funct3)
          3'b000:  dec_ctrl.mem_op = MEM_LB;
          3'b001:  dec_ctrl.mem_op = MEM_LH;
          3'b010:  dec_ctrl.mem_op = MEM_LW;
          3'b011:  dec_ctrl.mem_op = MEM_LD;
          3'b100:  dec_ctrl.mem_op = MEM_LBU;
          3'b101:  dec_ctrl.mem_op = MEM_LHU;
          3'b110:  dec_ctrl.mem_op = MEM_LWU;
          default: dec_bad = 1'b1;
        endcase
      end
      OPC_STORE: begin
        dec_ctrl.b_sel = BSEL_IMM;
        dec_bad        = funct3[2];
      end
      OPC_OP_IMM, OPC_OP_IMM32: begin
        dec_ctrl.b_sel   = BSEL_IMM;
        dec_ctrl.reg_wen = 1'b1;
        case (funct3)
          3'b000: dec_ctrl.alu_op = ALU_ADD;
          3'b010: dec_ctrl.alu_op = ALU_SLT;
          3'b011: dec_ctrl.alu_op = ALU_SLTU;
          3'b100: dec_ctrl.alu_op = ALU_XOR;
          3'b110: dec_ctrl.alu_op = ALU_OR;
          3'b111: dec_ctrl.alu_op = ALU_AND;
          3'b001: begin
            dec_ctrl.alu_op = ALU_SLL;
            dec_bad         = (i_inst[31:26] != 6'b0) || (is_word && i_inst[25]);
          end
          default: begin
            // srli or srai, bit 30 picks arithmetic
            dec_ctrl.alu_op = i_inst[30] ? ALU_SRA : ALU_SRL;
            dec_bad         = ({i_inst[31], i_inst[29:26]} != 5'b0) ||
                              (is_word && i_inst[25]);
          end
        endcase
        if (is_word && !(funct3 inside {3'b000, 3'b001, 3'b101})) begin
          dec_bad = 1'b1;
        end
      end
      OPC_OP, OPC_OP_32: begin
        dec_ctrl.reg_wen = 1'b1;
        case (funct7)
          F7_BASE: begin
            case (funct3)
              3'b000:  dec_ctrl.alu_op = ALU_ADD;
              3'b001:  dec_ctrl.alu_op = ALU_SLL;
              3'b010:  dec_ctrl.alu_op = ALU_SLT;
              3'b011:  dec_ctrl.alu_op = ALU_SLTU;
              3'b100:  dec_ctrl.alu_op = ALU_XOR;
              3'b101:  dec_ctrl.alu_op = ALU_SRL;
              3'b110:  dec_ctrl.alu_op = ALU_OR;
              default: dec_ctrl.alu_op = ALU_AND;
            endcase
            dec_bad = is_word && !(funct3 inside {3'b000, 3'b001, 3'b101});
          end
          F7_ALT: begin
            dec_ctrl.alu_op = (funct3 == 3'b000) ? ALU_SUB : ALU_SRA;
            dec_bad         = !(funct3 inside {3'b000, 3'b101});
          end
          F7_MULDIV: begin
            case (funct3)
              3'b000:  dec_ctrl.alu_op = ALU_MUL;
              3'b100:  dec_ctrl.alu_op = ALU_DIV;
              3'b101:  dec_ctrl.alu_op = ALU_DIVU;
              3'b110:  dec_ctrl.alu_op = ALU_REM;
              3'b111:  dec_ctrl.alu_op = ALU_REMU;
              // mulh, mulhsu, mulhu
              default: dec_bad = 1'b1;
            endcase
          end
          default: dec_bad = 1'b1;
        endcase
      end
      OPC_SYSTEM: begin
        dec_ctrl.halt = (i_inst == INST_EBREAK);
        dec_bad       = (i_inst != INST_EBREAK);
      end
      default: dec_bad = 1'b1;
    endcase

    // illegal falls through as a plain pc+4 with no side effects
    if (dec_bad) begin
      dec_ctrl.branch     = BR_NONE;
      dec_ctrl.mem_to_reg = 1'b0;
      dec_ctrl.reg_wen    = 1'b0;
      dec_ctrl.halt       = 1'b0;
      dec_ctrl.illegal    = 1'b1;
    end
    dec_ctrl.rd = dec_ctrl.reg_wen ? i_inst[11:7] : 5'd0;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_exe.valid <= 1'b0;
      o_exe.ctrl  <= '0;
    end else begin
      o_exe.valid <= i_valid;
      o_exe.ctrl  <= dec_ctrl;
    end
  end

  always_ff @(posedge i_clk) begin
    o_exe.pc    <= i_pc;
    o_exe.rs1   <= i_rs1;
    o_exe.rs2   <= i_rs2;
    o_exe.imm   <= dec_imm;
    o_exe.rdata <= i_rdata;
  end

endmodule

/* hw/exu_alu.sv */
// execute stage: operand select, alu with m-extension, branch decision, next pc
`timescale 1ns/1ps

module exu_alu import exu_pkg::*; (
  input  logic   i_clk,
  input  logic   i_rst,
  dec_exe_if.dst i_dec,
  exe_wb_if.src  o_wb
);

  exu_ctrl_t              ctrl;
  logic [XLEN-1:0]        src_a, src_b;
  logic [XLEN-1:0]        a_s, a_u, b_s, b_u;
  logic [5:0]             shamt;
  logic                   slt, sltu;
  logic [XLEN-1:0]        sra_res;
  logic                   div_zero, div_ovf;
  logic signed [XLEN-1:0] sdiv_q, sdiv_r;
  logic [XLEN-1:0]        udiv_q, udiv_r;
  logic [XLEN-1:0]        alu_raw, alu_result;
  logic                   br_eq, br_lt, br_ltu, br_taken;
  logic [XLEN-1:0]        nextpc;

  assign ctrl  = i_dec.ctrl;
  assign src_a = ctrl.a_sel_pc ? i_dec.pc : i_dec.rs1;

  always_comb begin
    case (ctrl.b_sel)
      BSEL_IMM:  src_b = i_dec.imm;
      BSEL_FOUR: src_b = XLEN'(4);
      default:   src_b = i_dec.rs2;
    endcase
  end

  // word forms: signed and unsigned views of the low word
  assign a_s = ctrl.word_cut ? {{(XLEN-32){src_a[31]}}, src_a[31:0]} : src_a;
  assign a_u = ctrl.word_cut ? {{(XLEN-32){1'b0}}, src_a[31:0]} : src_a;
  assign b_s = ctrl.word_cut ? {{(XLEN-32){src_b[31]}}, src_b[31:0]} : src_b;
  assign b_u = ctrl.word_cut ? {{(XLEN-32){1'b0}}, src_b[31:0]} : src_b;

  assign shamt = ctrl.word_cut ? {1'b0, src_b[4:0]} : src_b[5:0];

  assign slt     = $signed(src_a) < $signed(src_b);
  assign sltu    = src_a < src_b;
  assign sra_res = $signed(a_s) >>> shamt;

  // divider, special cases handled by the mux below
  assign div_zero = (b_u == '0);
  assign div_ovf  = (a_s == {1'b1, {(XLEN-1){1'b0}}}) && (b_s == '1);
  assign sdiv_q   = $signed(a_s) / $signed(b_s);
  assign sdiv_r   = $signed(a_s) % $signed(b_s);
  assign udiv_q   = a_u / b_u;
  assign udiv_r   = a_u % b_u;

  always_comb begin
    case (ctrl.alu_op)
      ALU_COPY: alu_raw = i_dec.imm;
      ALU_ADD:  alu_raw = a_u + b_u;
      ALU_SUB:  alu_raw = a_u - b_u;
      ALU_SLT:  alu_raw = {{(XLEN-1){1'b0}}, slt};
      ALU_SLTU: alu_raw = {{(XLEN-1){1'b0}}, sltu};
      ALU_XOR:  alu_raw = a_u ^ b_u;
      ALU_OR:   alu_raw = a_u | b_u;
      ALU_AND:  alu_raw = a_u & b_u;
      ALU_SLL:  alu_raw = a_u << shamt;
      ALU_SRL:  alu_raw = a_u >> shamt;
      ALU_SRA:  alu_raw = sra_res;
      ALU_MUL:  alu_raw = a_u * b_u;
      ALU_DIV: begin
        if (div_zero) begin
          alu_raw = '1;
        end else if (div_ovf) begin
          alu_raw = a_s;
        end else begin
          alu_raw = sdiv_q;
        end
      end
      ALU_DIVU: alu_raw = div_zero ? '1 : udiv_q;
      ALU_REM: begin
        if (div_zero) begin
          alu_raw = a_s;
        end else if (div_ovf) begin
          alu_raw = '0;
        end else begin
          alu_raw = sdiv_r;
        end
      end
      ALU_REMU: alu_raw = div_zero ? a_u : udiv_r;
      default:  alu_raw = '0;
    endcase
  end

  assign alu_result = ctrl.word_cut ? {{(XLEN-32){alu_raw[31]}}, alu_raw[31:0]} : alu_raw;

  // branches compare the raw register values
  assign br_eq  = (i_dec.rs1 == i_dec.rs2);
  assign br_lt  = $signed(i_dec.rs1) < $signed(i_dec.rs2);
  assign br_ltu = i_dec.rs1 < i_dec.rs2;

  always_comb begin
    case (ctrl.branch)
      BR_JAL:  br_taken = 1'b1;
      BR_EQ:   br_taken = br_eq;
      BR_NE:   br_taken = !br_eq;
      BR_LT:   br_taken = br_lt;
      BR_GE:   br_taken = !br_lt;
      BR_LTU:  br_taken = br_ltu;
      BR_GEU:  br_taken = !br_ltu;
      default: br_taken = 1'b0;
    endcase
  end

  always_comb begin
    if (ctrl.branch == BR_JALR) begin
      nextpc = (i_dec.rs1 + i_dec.imm) & ~XLEN'(1);
    end else if (br_taken) begin
      nextpc = i_dec.pc + i_dec.imm;
    end else begin
      nextpc = i_dec.pc + XLEN'(4);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_wb.valid <= 1'b0;
      o_wb.ctrl  <= '0;
    end else begin
      o_wb.valid <= i_dec.valid;
      o_wb.ctrl  <= ctrl;
    end
  end

  always_ff @(posedge i_clk) begin
    o_wb.alu_result <= alu_result;
    o_wb.nextpc     <= nextpc;
    o_wb.rdata      <= i_dec.rdata;
  end

endmodule

/* hw/wbu_load_ext.sv */
// writeback stage: load data extension and write-back value select
`timescale 1ns/1ps

module wbu_load_ext import exu_pkg::*; (
  input  logic            i_clk,
  input  logic            i_rst,
  exe_wb_if.dst           i_wb,
  output logic            o_valid,
  output logic [XLEN-1:0] o_alu_result,
  output logic [XLEN-1:0] o_nextpc,
  output logic [XLEN-1:0] o_busw,
  output logic [4:0]      o_rd,
  output logic            o_wen,
  output logic            o_halt,
  output logic            o_illegal
);

  logic [XLEN-1:0] load_val;
  logic [XLEN-1:0] busw;

  always_comb begin
    case (i_wb.ctrl.mem_op)
      MEM_LB:  load_val = {{(XLEN-8){i_wb.rdata[7]}}, i_wb.rdata[7:0]};
      MEM_LBU: load_val = {{(XLEN-8){1'b0}}, i_wb.rdata[7:0]};
      MEM_LH:  load_val = {{(XLEN-16){i_wb.rdata[15]}}, i_wb.rdata[15:0]};
      MEM_LHU: load_val = {{(XLEN-16){1'b0}}, i_wb.rdata[15:0]};
      MEM_LW:  load_val = {{(XLEN-32){i_wb.rdata[31]}}, i_wb.rdata[31:0]};
      // lwu is a true zero extension
      MEM_LWU: load_val = {{(XLEN-32){1'b0}}, i_wb.rdata[31:0]};
      default: load_val = i_wb.rdata;
    endcase
  end

  assign busw = i_wb.ctrl.mem_to_reg ? load_val : i_wb.alu_result;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid   <= 1'b0;
      o_wen     <= 1'b0;
      o_halt    <= 1'b0;
      o_illegal <= 1'b0;
    end else begin
      o_valid   <= i_wb.valid;
      o_wen     <= i_wb.valid && i_wb.ctrl.reg_wen;
      o_halt    <= i_wb.valid && i_wb.ctrl.halt;
      o_illegal <= i_wb.valid && i_wb.ctrl.illegal;
    end
  end

  always_ff @(posedge i_clk) begin
    o_alu_result <= i_wb.alu_result;
    o_nextpc     <= i_wb.nextpc;
    o_busw       <= busw;
    o_rd         <= i_wb.ctrl.rd;
  end

endmodule

/* hw/core_exec_top.sv */
// core_exec top: decode, execute and writeback chained as a three-stage pipeline
`timescale 1ns/1ps

module core_exec_top import exu_pkg::*; (
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic            i_valid,
  input  logic [ILEN-1:0] i_inst,
  input  logic [XLEN-1:0] i_pc,
  input  logic [XLEN-1:0] i_rs1,
  input  logic [XLEN-1:0] i_rs2,
  input  logic [XLEN-1:0] i_rdata,
  output logic            o_valid,
  output logic [XLEN-1:0] o_alu_result,
  output logic [XLEN-1:0] o_nextpc,
  output logic [XLEN-1:0] o_busw,
  output logic [4:0]      o_rd,
  output logic            o_wen,
  output logic            o_halt,
  output logic            o_illegal
);

  dec_exe_if u_dec_exe ();
  exe_wb_if  u_exe_wb ();

  idu_decode u_idu (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_valid (i_valid),
    .i_inst  (i_inst),
    .i_pc    (i_pc),
    .i_rs1   (i_rs1),
    .i_rs2   (i_rs2),
    .i_rdata (i_rdata),
    .o_exe   (u_dec_exe.src)
  );

  exu_alu u_exu (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_dec (u_dec_exe.dst),
    .o_wb  (u_exe_wb.src)
  );

  wbu_load_ext u_wbu (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_wb         (u_exe_wb.dst),
    .o_valid      (o_valid),
    .o_alu_result (o_alu_result),
    .o_nextpc     (o_nextpc),
    .o_busw       (o_busw),
    .o_rd         (o_rd),
    .o_wen        (o_wen),
    .o_halt       (o_halt),
    .o_illegal    (o_illegal)
  );

endmodule

/* tb/tb_clkgen.sv */
// testbench clock and reset source, 10 ns clock with a synchronous reset pulse
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int RST_CYCLES = 8
) (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk;
  end

  // released on a falling edge like the other inputs
  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rst = 1'b0;
  end

endmodule

/* tb/tb_core_exec.sv */
// core_exec testbench with random instruction stimulus, a reference model and output assertions
`timescale 1ns/1ps

module tb_core_exec import exu_pkg::*; ();

  localparam int RST_CYCLES = 8;
  localparam int N_INSTR    = 165;

  typedef struct packed {
    logic [63:0] busw;
    logic [63:0] nextpc;
    logic [63:0] alu;
    logic        alu_chk;
    logic        wen;
    logic [4:0]  rd;
    logic        halt;
    logic        illegal;
  } exp_t;

  logic        clk;
  logic        rst;
  logic        i_valid;
  logic [31:0] i_inst;
  logic [63:0] i_pc, i_rs1, i_rs2, i_rdata;
  logic        o_valid, o_wen, o_halt, o_illegal;
  logic [63:0] o_alu_result, o_nextpc, o_busw;
  logic [4:0]  o_rd;

  // expected results aligned with i_valid
  exp_t        cur;
  int          issued = 0;
  int          retired = 0;
  int          cycles = 0;
  int          test_errs = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  string       test_name;
  logic [2:0]  md_f3 [5] = '{3'b000, 3'b100, 3'b101, 3'b110, 3'b111};
  logic [2:0]  br_f3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

  tb_clkgen #(.RST_CYCLES(RST_CYCLES)) u_clkgen (
    .o_clk (clk),
    .o_rst (rst)
  );

  core_exec_top dut (
    .i_clk        (clk),
    .i_rst        (rst),
    .i_valid      (i_valid),
    .i_inst       (i_inst),
    .i_pc         (i_pc),
    .i_rs1        (i_rs1),
    .i_rs2        (i_rs2),
    .i_rdata      (i_rdata),
    .o_valid      (o_valid),
    .o_alu_result (o_alu_result),
    .o_nextpc     (o_nextpc),
    .o_busw       (o_busw),
    .o_rd         (o_rd),
    .o_wen        (o_wen),
    .o_halt       (o_halt),
    .o_illegal    (o_illegal)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (!rst && o_valid) begin
      retired <= retired + 1;
    end
  end

  task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
    $display("mismatch %s expected 0x%h got 0x%h at %0t", name, exp_v, act_v, $time);
    test_errs++;
  endtask

  task automatic report_failure(input string msg);
    $display("error: %s at %0t", msg, $time);
    test_errs++;
  endtask

  a_reset: assert property (@(posedge clk) (cycles > 1 && $past(rst)) |->
      !(o_valid || o_wen || o_halt || o_illegal))
    else report_failure("control outputs were not cleared by reset");

  // instructions offered during reset are dropped
  a_valid: assert property (@(posedge clk) disable iff (rst)
      o_valid == $past(i_valid && !rst, 3))
    else report_mismatch("o_valid", $past(i_valid && !rst, 3), $sampled(o_valid));

  a_busw: assert property (@(posedge clk) disable iff (rst)
      (o_valid && $past(cur.wen, 3)) |-> o_busw == $past(cur.busw, 3))
    else report_mismatch("o_busw", $past(cur.busw, 3), $sampled(o_busw));

  a_alu: assert property (@(posedge clk) disable iff (rst)
      (o_valid && $past(cur.alu_chk, 3)) |-> o_alu_result == $past(cur.alu, 3))
    else report_mismatch("o_alu_result", $past(cur.alu, 3), $sampled(o_alu_result));

  a_nextpc: assert property (@(posedge clk) disable iff (rst)
      o_valid |-> o_nextpc == $past(cur.nextpc, 3))
    else report_mismatch("o_nextpc", $past(cur.nextpc, 3), $sampled(o_nextpc));

  a_wen: assert property (@(posedge clk) disable iff (rst)
      o_valid |-> o_wen == $past(cur.wen, 3))
    else report_mismatch("o_wen", $past(cur.wen, 3), $sampled(o_wen));

  a_rd: assert property (@(posedge clk) disable iff (rst)
      o_valid |-> o_rd == $past(cur.rd, 3))
    else report_mismatch("o_rd", $past(cur.rd, 3), $sampled(o_rd));

  a_halt: assert property (@(posedge clk) disable iff (rst)
      o_valid |-> o_halt == $past(cur.halt, 3))
    else report_mismatch("o_halt", $past(cur.halt, 3), $sampled(o_halt));

  a_illegal: assert property (@(posedge clk) disable iff (rst)
      o_valid |-> o_illegal == $past(cur.illegal, 3))
    else report_mismatch("o_illegal", $past(cur.illegal, 3), $sampled(o_illegal));

  function automatic logic [63:0] rnd64();
    return {$urandom, $urandom};
  endfunction

  // integer and m-extension results per the isa
  function automatic logic [63:0] arith(input logic [2:0] f3, input logic alt,
                                        input logic md, input logic w,
                                        input logic [63:0] a, input logic [63:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic [63:0]        ua;
    logic [63:0]        ub;
    logic [5:0]         sh;
    logic               ovf;
    logic [63:0]        r;
    sa  = w ? {{32{a[31]}}, a[31:0]} : a;
    sb  = w ? {{32{b[31]}}, b[31:0]} : b;
    ua  = w ? {32'b0, a[31:0]} : a;
    ub  = w ? {32'b0, b[31:0]} : b;
    sh  = w ? {1'b0, b[4:0]} : b[5:0];
    ovf = (sa == {1'b1, 63'b0}) && (sb == '1);
    case ({md, f3})
      4'b0000: r = alt ? a - b : a + b;
      4'b0001: r = a << sh;
      4'b0010: r = {63'b0, $signed(a) < $signed(b)};
      4'b0011: r = {63'b0, a < b};
      4'b0100: r = a ^ b;
      4'b0110: r = a | b;
      4'b0111: r = a & b;
      4'b1000: r = a * b;
      4'b1101: r = (ub == '0) ? '1 : ua / ub;
      4'b1111: r = (ub == '0) ? ua : ua % ub;
      4'b0101: begin
        if (alt) begin
          r = sa >>> sh;
        end else begin
          r = ua >> sh;
        end
      end
      4'b1100: begin
        if (ub == '0) begin
          r = '1;
        end else if (ovf) begin
          r = sa;
        end else begin
          r = sa / sb;
        end
      end
      default: begin
        if (ub == '0) begin
          r = sa;
        end else if (ovf) begin
          r = '0;
        end else begin
          r = sa % sb;
        end
      end
    endcase
    if (w) begin
      r = {{32{r[31]}}, r[31:0]};
    end
    return r;
  endfunction

  function automatic exp_t model(input logic [31:0] inst, input logic [63:0] pc,
                                 input logic [63:0] a, input logic [63:0] b,
                                 input logic [63:0] rdata);
    exp_t        e;
    logic [2:0]  f3;
    logic        w;
    logic        taken;
    logic [63:0] imm_i;
    logic [63:0] imm_u;
    f3       = inst[14:12];
    w        = (inst[6:0] == OPC_OP_32) || (inst[6:0] == OPC_OP_IMM32);
    imm_i    = {{52{inst[31]}}, inst[31:20]};
    imm_u    = {{32{inst[31]}}, inst[31:12], 12'b0};
    e        = '0;
    e.nextpc = pc + 64'd4;
    e.wen    = 1'b1;
    case (inst[6:0])
      OPC_LUI:   e.busw = imm_u;
      OPC_AUIPC: e.busw = pc + imm_u;
      OPC_JAL: begin
        e.busw   = pc + 64'd4;
        e.nextpc = pc + {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      OPC_JALR: begin
        e.busw   = pc + 64'd4;
        e.nextpc = (a + imm_i) & ~64'd1;
      end
      OPC_BRANCH: begin
        case (f3)
          3'b000:  taken = a == b;
          3'b001:  taken = a != b;
          3'b100:  taken = $signed(a) < $signed(b);
          3'b101:  taken = $signed(a) >= $signed(b);
          3'b110:  taken = a < b;
          default: taken = a >= b;
        endcase
        e.wen = 1'b0;
        if (taken) begin
          e.nextpc = pc + {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        end
      end
      OPC_LOAD: begin
        e.alu     = a + imm_i;
        e.alu_chk = 1'b1;
        case (f3)
          3'b000:  e.busw = {{56{rdata[7]}}, rdata[7:0]};
          3'b001:  e.busw = {{48{rdata[15]}}, rdata[15:0]};
          3'b010:  e.busw = {{32{rdata[31]}}, rdata[31:0]};
          3'b100:  e.busw = {56'b0, rdata[7:0]};
          3'b101:  e.busw = {48'b0, rdata[15:0]};
          3'b110:  e.busw = {32'b0, rdata[31:0]};
          default: e.busw = rdata;
        endcase
      end
      OPC_STORE: begin
        e.wen     = 1'b0;
        e.alu     = a + {{52{inst[31]}}, inst[31:25], inst[11:7]};
        e.alu_chk = 1'b1;
      end
      OPC_OP, OPC_OP_32: begin
        // mulh, mulhsu and mulhu are outside the slice
        if (inst[25] && f3 inside {3'b001, 3'b010, 3'b011}) begin
          e.illegal = 1'b1;
        end else begin
          e.busw = arith(f3, inst[30], inst[25], w, a, b);
        end
      end
      OPC_OP_IMM, OPC_OP_IMM32: e.busw = arith(f3, inst[30] && f3 == 3'b101, 1'b0, w, a, imm_i);
      OPC_SYSTEM: begin
        e.halt    = (inst == 32'h0010_0073);
        e.illegal = !e.halt;
        e.wen     = 1'b0;
      end
      default: e.illegal = 1'b1;
    endcase
    if (e.illegal) begin
      e.wen = 1'b0;
    end
    if (e.wen && inst[6:0] != OPC_LOAD) begin
      e.alu     = e.busw;
      e.alu_chk = 1'b1;
    end
    e.rd = e.wen ? inst[11:7] : 5'd0;
    return e;
  endfunction

  task automatic issue(input logic [31:0] inst, input logic [63:0] a, input logic [63:0] b);
    logic [63:0] pc;
    logic [63:0] rdata;
    pc    = rnd64() & ~64'h3;
    rdata = rnd64();
    @(negedge clk);
    i_valid = 1'b1;
    i_inst  = inst;
    i_pc    = pc;
    i_rs1   = a;
    i_rs2   = b;
    i_rdata = rdata;
    cur     = model(inst, pc, a, b, rdata);
    issued++;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  // stop issuing and wait until every result has come out
  task automatic end_test();
    @(negedge clk);
    i_valid = 1'b0;
    cur     = '0;
    while (retired != issued) begin
      @(posedge clk);
    end
    if (test_errs == 0) begin
      pass_cnt++;
      $display("test %s: ok", test_name);
    end else begin
      fail_cnt++;
      $display("test %s: %0d errors", test_name, test_errs);
    end
  endtask

  initial begin : watchdog
    #((N_INSTR + 50 + RST_CYCLES) * 10);
    $display("error: timeout, results did not arrive in time");
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin : main
    logic [31:0] r;
    logic [2:0]  f3;
    logic        alt;
    logic [63:0] a;
    logic [63:0] b;
    logic [31:0] inst;
    logic [6:0]  opc;
    void'($urandom(32968));
    i_valid = 1'b1;
    i_inst  = 32'h0010_0073;
    i_pc    = '0;
    i_rs1   = '0;
    i_rs2   = '0;
    i_rdata = '0;
    cur     = '0;

    begin_test("reset and alu");
    // halt, illegal and writing instructions offered while reset holds
    for (int k = 0; k < RST_CYCLES - 1; k++) begin
      @(negedge clk);
      case (k % 3)
        0:       i_inst = 32'h0010_0073;
        1:       i_inst = 32'h0000_0073;
        default: i_inst = {12'h001, 5'd1, 3'b000, 5'd1, OPC_OP_IMM};
      endcase
    end
    wait (!rst);
    i_valid = 1'b0;
    repeat (40) begin
      r   = $urandom;
      f3  = r[14:12];
      alt = r[30] && (f3 == 3'b000 || f3 == 3'b101);
      if (r[0]) begin
        issue({1'b0, alt, 5'b0, r[24:15], f3, r[11:7], OPC_OP}, rnd64(), rnd64());
      end else if (f3 == 3'b001 || f3 == 3'b101) begin
        issue({1'b0, alt && f3[2], 4'b0, r[25:15], f3, r[11:7], OPC_OP_IMM}, rnd64(), rnd64());
      end else begin
        issue({r[31:15], f3, r[11:7], OPC_OP_IMM}, rnd64(), rnd64());
      end
    end
    end_test();

    begin_test("word forms");
    repeat (30) begin
      r   = $urandom;
      f3  = r[0] ? 3'b101 : (r[1] ? 3'b001 : 3'b000);
      alt = r[30] && f3 != 3'b001;
      a   = rnd64() | 64'h8000_0000;
      if (r[2]) begin
        issue({1'b0, alt, 5'b0, r[24:15], f3, r[11:7], OPC_OP_32}, a, rnd64());
      end else if (f3 == 3'b000) begin
        issue({r[31:15], f3, r[11:7], OPC_OP_IMM32}, a, rnd64());
      end else begin
        issue({1'b0, alt, 5'b0, r[24:15], f3, r[11:7], OPC_OP_IMM32}, a, rnd64());
      end
    end
    end_test();

    begin_test("m extension");
    foreach (md_f3[i]) begin
      for (int w = 0; w < 2; w++) begin
        r    = $urandom;
        opc  = w ? OPC_OP_32 : OPC_OP;
        inst = {7'b0000001, r[24:15], md_f3[i], r[11:7], opc};
        issue(inst, rnd64(), rnd64());
        // zero divisor with the upper half ignored by word forms
        issue(inst, rnd64(), w ? {$urandom, 32'h0} : 64'h0);
        if (w) begin
          issue(inst, {$urandom, 32'h8000_0000}, {$urandom, 32'hffff_ffff});
        end else begin
          issue(inst, 64'h8000_0000_0000_0000, '1);
        end
      end
    end
    end_test();

    begin_test("control flow");
    foreach (br_f3[i]) begin
      r    = $urandom;
      a    = rnd64();
      b    = rnd64();
      inst = {r[31:15], br_f3[i], r[11:7], OPC_BRANCH};
      issue(inst, a, a);
      issue(inst, a, b);
      issue(inst, b, a);
      issue(inst, a ^ 64'h8000_0000_0000_0000, a);
    end
    repeat (2) begin
      r = $urandom;
      issue({r[31:7], OPC_JAL}, rnd64(), rnd64());
      issue({r[31:15], 3'b000, r[11:7], OPC_JALR}, rnd64(), rnd64());
      issue({r[31:7], OPC_LUI}, rnd64(), rnd64());
      issue({r[31:7], OPC_AUIPC}, rnd64(), rnd64());
    end
    end_test();

    begin_test("loads and stores");
    for (int k = 0; k < 7; k++) begin
      repeat (3) begin
        r = $urandom;
        issue({r[31:15], 3'(k), r[11:7], OPC_LOAD}, rnd64(), rnd64());
      end
    end
    for (int k = 0; k < 4; k++) begin
      repeat (2) begin
        r = $urandom;
        issue({r[31:15], 3'(k), r[11:7], OPC_STORE}, rnd64(), rnd64());
      end
    end
    end_test();

    begin_test("flags");
    r = $urandom;
    issue(32'h0010_0073, rnd64(), rnd64());
    issue(32'h0000_0073, rnd64(), rnd64());
    issue({r[31:7], 7'b0001011}, rnd64(), rnd64());
    issue({7'b0000001, r[24:15], 3'b001, r[11:7], OPC_OP}, rnd64(), rnd64());
    end_test();

    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* core_exec.f */
hw/exu_pkg.sv
hw/exu_stage_if.sv
hw/idu_decode.sv
hw/exu_alu.sv
hw/wbu_load_ext.sv
hw/core_exec_top.sv
tb/tb_clkgen.sv
tb/tb_core_exec.sv

/* Bender.yml */
package:
  name: core_exec

sources:
  - files:
      - hw/exu_pkg.sv
      - hw/exu_stage_if.sv
      - hw/idu_decode.sv
      - hw/exu_alu.sv
      - hw/wbu_load_ext.sv
      - hw/core_exec_top.sv
  - target: test
    files:
      - tb/tb_clkgen.sv
      - tb/tb_core_exec.sv
